/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Boot vector, first fetch after reset
// Lies in kseg1, so it is unmapped and uncached
`define FETCH_RESET_PC 32'hBFC00000

// Instruction RAM word address width
// 1024 words of 32 bits
`define IMEM_ADDR_W 10

// Cycles from an accepted read to valid
`define IMEM_LATENCY 2

// Segment boundaries of the virtual address space
// useg   0x00000000 .. 0x7FFFFFFF  mapped, not translated here
// kseg0  0x80000000 .. 0x9FFFFFFF  unmapped, cached
// kseg1  0xA0000000 .. 0xBFFFFFFF  unmapped, uncached
// kseg2  0xC0000000 .. 0xFFFFFFFF  mapped, kseg3 included
`define SEG_KSEG0_BASE 32'h80000000
`define SEG_KSEG2_BASE 32'hC0000000

`endif

/* hdl/fetchPkg.sv */
package fetchPkg;

    // Virtual address segment of a fetch request
    typedef enum logic [1:0] {
        SEG_USEG,
        SEG_KSEG0,
        SEG_KSEG1,
        SEG_KSEG2
    } segKind_e;

    // Fetch unit to translator
    typedef struct packed {
        logic [31:0] vaddr;
        logic        readEn;
    } fetchReq_t;

    // Translator and RAM back to the fetch unit
    typedef struct packed {
        logic [31:0] rdata;
        logic        valid;
        logic        addressError;
        logic        tlbMiss;
        logic        tlbInvalid;
        logic        tlbReady;
    } memResp_t;

    // Fetched word as seen by the pipeline
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        addressError;
        logic        tlbMiss;
        logic        tlbInvalid;
        logic        isDelaySlot;
    } fetchOut_t;

endpackage

/* hdl/instFetch.sv */
`include "fetch_consts.svh"

module instFetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                absJump_i,
    input  logic [31:0]         absJumpAddress_i,
    input  logic                stall_i,
    input  logic                exception_i,
    output fetchPkg::fetchReq_t fetchReq_o,
    input  fetchPkg::memResp_t  memResp_i,
    output fetchPkg::fetchOut_t fetched_o,
    output logic                bubble_o
);

    logic [31:0] pc;
    logic [31:0] pcNext;
    logic        pcFromJump;
    logic        jumpTaken;
    logic        advance;
    logic        readEn;
    logic        running;

    logic        pendingJump;
    logic        pendingJumpNext;
    logic [31:0] pendingJumpAddr;
    logic        pendingExc;
    logic        pendingExcNext;

    logic        busy;
    logic        busyNext;
    logic        pcMisaligned;
    logic        currentFault;
    logic        hasResponse;
    logic        canSend;
    logic        wantExc;
    logic        wantJump;
    logic        bubble;

    logic        latchResult;
    logic        latchResultNext;
    logic [31:0] lastInstr;
    logic        lastAddressError;
    logic        lastTlbMiss;
    logic        lastTlbInvalid;

    assign pcMisaligned = pc[1:0] != 2'b00;
    assign currentFault = memResp_i.addressError || memResp_i.tlbMiss ||
                          memResp_i.tlbInvalid || pcMisaligned;
    assign hasResponse  = (memResp_i.valid || currentFault) && memResp_i.tlbReady;

    // One read in flight at most
    assign canSend  = hasResponse || !busy;
    assign wantExc  = exception_i || pendingExc;
    assign wantJump = absJump_i || pendingJump;

    // An exception swallows whatever arrives
    assign bubble   = wantExc || !hasResponse;
    assign bubble_o = latchResult ? 1'b0 : bubble;

    always_comb begin
        if (stall_i && !bubble) begin
            latchResultNext = 1'b1;
        end else if (!stall_i) begin
            latchResultNext = 1'b0;
        end else begin
            latchResultNext = latchResult;
        end
    end

    always_comb begin
        pcNext          = pc;
        readEn          = 1'b0;
        jumpTaken       = 1'b0;
        advance         = 1'b0;
        pendingExcNext  = wantExc;
        pendingJumpNext = wantJump;
        if (running && canSend && !stall_i && (wantJump || !wantExc)) begin
            advance         = 1'b1;
            pendingExcNext  = 1'b0;
            pendingJumpNext = 1'b0;
            if (absJump_i) begin
                pcNext    = absJumpAddress_i;
                jumpTaken = 1'b1;
            end else if (pendingJump) begin
                pcNext    = pendingJumpAddr;
                jumpTaken = 1'b1;
            end else if (!bubble_o) begin
                pcNext = pc + 32'd4;
            end
            // Misaligned PC faults locally, nothing goes to memory
            readEn = pcNext[1:0] == 2'b00;
        end
    end

    assign busyNext = readEn ? 1'b1 : (hasResponse ? 1'b0 : busy);

    assign fetchReq_o = '{vaddr: pcNext, readEn: readEn};

    always_comb begin
        fetched_o.pc          = pc;
        fetched_o.isDelaySlot = pcFromJump;
        if (latchResult) begin
            fetched_o.instr        = lastInstr;
            fetched_o.addressError = lastAddressError;
            fetched_o.tlbMiss      = lastTlbMiss;
            fetched_o.tlbInvalid   = lastTlbInvalid;
        end else begin
            fetched_o.instr        = memResp_i.rdata;
            fetched_o.addressError = memResp_i.addressError || pcMisaligned;
            fetched_o.tlbMiss      = memResp_i.tlbMiss;
            fetched_o.tlbInvalid   = memResp_i.tlbInvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc               <= `FETCH_RESET_PC;
            pcFromJump       <= 1'b0;
            running          <= 1'b0;
            pendingJump      <= 1'b0;
            pendingExc       <= 1'b0;
            busy             <= 1'b0;
            latchResult      <= 1'b0;
            lastAddressError <= 1'b0;
            lastTlbMiss      <= 1'b0;
            lastTlbInvalid   <= 1'b0;
        end else begin
            running     <= 1'b1;
            pendingJump <= pendingJumpNext;
            pendingExc  <= pendingExcNext;
            busy        <= busyNext;
            latchResult <= latchResultNext;
            if (advance) begin
                pc         <= pcNext;
                pcFromJump <= jumpTaken;
            end
            lastAddressError <= fetched_o.addressError;
            lastTlbMiss      <= fetched_o.tlbMiss;
            lastTlbInvalid   <= fetched_o.tlbInvalid;
        end
    end

    always_ff @(posedge clk) begin
        lastInstr <= fetched_o.instr;
        if (absJump_i) begin
            pendingJumpAddr <= absJumpAddress_i;
        end
    end

endmodule

/* hdl/addrTranslate.sv */
`include "fetch_consts.svh"

module addrTranslate (
    input  logic                clk,
    input  logic                reset,
    input  fetchPkg::fetchReq_t req_i,
    output logic [31:0]         physAddr_o,
    output logic                go_o,
    input  logic                ramValid_i,
    input  logic [31:0]         ramData_i,
    output fetchPkg::memResp_t  resp_o
);

    import fetchPkg::*;

    fetchReq_t reqQ;
    segKind_e  seg;
    logic      misaligned;
    logic      ramWait;
    logic      ramHit;

    function automatic segKind_e classify(input logic [31:0] vaddr);
        segKind_e kind;
        if (vaddr < `SEG_KSEG0_BASE) begin
            kind = SEG_USEG;
        end else if (vaddr >= `SEG_KSEG2_BASE) begin
            kind = SEG_KSEG2;
        end else if (vaddr[29]) begin
            kind = SEG_KSEG1;
        end else begin
            kind = SEG_KSEG0;
        end
        return kind;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            reqQ.readEn <= 1'b0;
            ramWait     <= 1'b0;
        end else begin
            reqQ.readEn <= req_i.readEn;
            if (go_o) begin
                ramWait <= 1'b1;
            end else if (ramValid_i) begin
                ramWait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        reqQ.vaddr <= req_i.vaddr;
    end

    assign seg        = classify(reqQ.vaddr);
    assign misaligned = reqQ.vaddr[1:0] != 2'b00;

    // kseg0 and kseg1 map straight onto the low 512 MB
    assign physAddr_o = {3'b000, reqQ.vaddr[28:0]};
    assign go_o = reqQ.readEn && !misaligned && (seg == SEG_KSEG0 || seg == SEG_KSEG1);

    // Only a read we are still waiting on counts as a hit
    assign ramHit = ramValid_i && ramWait;

    assign resp_o.rdata        = ramData_i;
    assign resp_o.valid        = ramHit;
    assign resp_o.addressError = reqQ.readEn && misaligned;
    assign resp_o.tlbMiss      = reqQ.readEn && seg == SEG_USEG;
    assign resp_o.tlbInvalid   = reqQ.readEn && seg == SEG_KSEG2;
    assign resp_o.tlbReady     = !(go_o || ramWait) || ramHit;

endmodule

/* hdl/instRam.sv */
`include "fetch_consts.svh"

module instRam (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`IMEM_ADDR_W-1:0] addr_i,
    input  logic                    rdEn_i,
    input  logic                    loadEn_i,
    input  logic [`IMEM_ADDR_W-1:0] loadAddr_i,
    input  logic [31:0]             loadData_i,
    output logic [31:0]             rdata_o,
    output logic                    valid_o
);

    localparam int Depth = 1 << `IMEM_ADDR_W;
    localparam int Lat   = `IMEM_LATENCY;

    logic [31:0]    mem [Depth];
    logic [31:0]    dataPipe [Lat];
    logic [Lat-1:0] validPipe;

    // Boot code load, one word per cycle
    always_ff @(posedge clk) begin
        if (loadEn_i) begin
            mem[loadAddr_i] <= loadData_i;
        end
    end

    // First stage reads the array, the rest only delay
    always_ff @(posedge clk) begin
        if (rdEn_i) begin
            dataPipe[0] <= mem[addr_i];
        end
        for (int i = 1; i < Lat; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= rdEn_i;
            for (int i = 1; i < Lat; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign rdata_o = dataPipe[Lat-1];
    assign valid_o = validPipe[Lat-1];

endmodule

/* hdl/fetchTop.sv */
`include "fetch_consts.svh"

module fetchTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    absJump_i,
    input  logic [31:0]             absJumpAddress_i,
    input  logic                    stall_i,
    input  logic                    exception_i,
    input  logic                    loadEn_i,
    input  logic [`IMEM_ADDR_W-1:0] loadAddr_i,
    input  logic [31:0]             loadData_i,
    output fetchPkg::fetchOut_t     fetched_o,
    output logic                    bubble_o
);

    import fetchPkg::*;

    fetchReq_t   fetchReq;
    memResp_t    memResp;
    logic [31:0] physAddr;
    logic        ramGo;
    logic        ramValid;
    logic [31:0] ramData;

    instFetch uInstFetch (
        .clk              (clk),
        .reset            (reset),
        .absJump_i        (absJump_i),
        .absJumpAddress_i (absJumpAddress_i),
        .stall_i          (stall_i),
        .exception_i      (exception_i),
        .fetchReq_o       (fetchReq),
        .memResp_i        (memResp),
        .fetched_o        (fetched_o),
        .bubble_o         (bubble_o)
    );

    addrTranslate uAddrTranslate (
        .clk        (clk),
        .reset      (reset),
        .req_i      (fetchReq),
        .physAddr_o (physAddr),
        .go_o       (ramGo),
        .ramValid_i (ramValid),
        .ramData_i  (ramData),
        .resp_o     (memResp)
    );

    // Word index out of the byte address
    instRam uInstRam (
        .clk        (clk),
        .reset      (reset),
        .addr_i     (physAddr[`IMEM_ADDR_W+1:2]),
        .rdEn_i     (ramGo),
        .loadEn_i   (loadEn_i),
        .loadAddr_i (loadAddr_i),
        .loadData_i (loadData_i),
        .rdata_o    (ramData),
        .valid_o    (ramValid)
    );

endmodule

/* testbench/fetchTop_assert.sv */
`include "fetch_consts.svh"

module fetchTopAssert (
    input logic                clk,
    input logic                reset,
    input logic                stall_i,
    input logic                bubble_i,
    input logic                readEn_i,
    input logic                absJump_i,
    input logic                isDelaySlot_i,
    input fetchPkg::fetchOut_t fetched_i,
    input logic                ramGo_i,
    input logic                ramValid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int   failCount = 0;
    logic jumpSeen;

    always_ff @(posedge clk) begin
        if (reset) begin
            jumpSeen <= 1'b0;
        end else if (absJump_i) begin
            jumpSeen <= 1'b1;
        end
    end

    // A stalled word is held unchanged and no new read goes out
    assert property (@(posedge clk) disable iff (reset)
        (stall_i && !bubble_i) |-> !readEn_i ##1 (!bubble_i && $stable(fetched_i)))
        else begin
            $error("stalled word not held steady, or a read issued during the stall");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
        ramValid_i |-> $past(ramGo_i, `IMEM_LATENCY) && $past(readEn_i, `IMEM_LATENCY + 1))
        else begin
            $error("RAM valid without a matching fetch request and go strobe");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
        isDelaySlot_i |-> jumpSeen)
        else begin
            $error("delay slot flag set with no jump since reset");
            failCount++;
        end

endmodule

bind fetchTop fetchTopAssert uAssert (
    .clk           (clk),
    .reset         (reset),
    .stall_i       (stall_i),
    .bubble_i      (bubble_o),
    .readEn_i      (fetchReq.readEn),
    .absJump_i     (absJump_i),
    .isDelaySlot_i (fetched_o.isDelaySlot),
    .fetched_i     (fetched_o),
    .ramGo_i       (ramGo),
    .ramValid_i    (ramValid)
);

/* testbench/fetchChecker.sv */
`include "fetch_consts.svh"

module fetchChecker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    absJump_i,
    input  logic [31:0]             absJumpAddress_i,
    input  logic                    stall_i,
    input  logic                    exception_i,
    input  logic                    loadEn_i,
    input  logic [`IMEM_ADDR_W-1:0] loadAddr_i,
    input  logic [31:0]             loadData_i,
    input  fetchPkg::fetchOut_t     fetched_i,
    input  logic                    bubble_i,
    output int                      wordCount_o,
    output int                      errorCount_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import fetchPkg::*;

    logic [31:0] mirror [1 << `IMEM_ADDR_W];
    logic [31:0] expPc;
    logic        expDelay;
    logic        excActive;
    logic        jumpPending;
    logic [31:0] jumpTarget;
    logic        active;
    string       testName;
    int          testErrors;
    int          testWords;

    // Expected word at a PC, flags from the segment of the virtual address
    function automatic fetchOut_t expectWord(input logic [31:0] pc, input logic delay);
        fetchOut_t w;
        segKind_e  seg;
        w             = '0;
        w.pc          = pc;
        w.isDelaySlot = delay;
        if (!pc[31]) begin
            seg = SEG_USEG;
        end else if (pc[30]) begin
            seg = SEG_KSEG2;
        end else begin
            seg = pc[29] ? SEG_KSEG1 : SEG_KSEG0;
        end
        // Misaligned PC never reaches the translator
        if (pc[1:0] != 2'b00) begin
            w.addressError = 1'b1;
        end else if (seg == SEG_USEG) begin
            w.tlbMiss = 1'b1;
        end else if (seg == SEG_KSEG2) begin
            w.tlbInvalid = 1'b1;
        end else begin
            w.instr = mirror[pc[`IMEM_ADDR_W+1:2]];
        end
        return w;
    endfunction

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = 0;
        testWords  = 0;
        active     = 1'b1;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("[OK] %s: %0d words checked", testName, testWords);
        end else begin
            $display("[FAIL] %s: %0d mismatches over %0d words", testName, testErrors, testWords);
        end
    endtask

    task automatic reportMismatch(input fetchOut_t want, input fetchOut_t got);
        $display("[ERROR] %s: expected pc=%h instr=%h flags=%b, actual pc=%h instr=%h flags=%b",
                 testName, want.pc, want.instr, want[3:0], got.pc, got.instr, got[3:0]);
        errorCount_o++;
        testErrors++;
    endtask

    initial begin
        wordCount_o  = 0;
        errorCount_o = 0;
        active       = 1'b0;
    end

    always @(posedge clk) begin
        fetchOut_t want;
        fetchOut_t got;
        if (loadEn_i) begin
            mirror[loadAddr_i] = loadData_i;
        end
        if (reset) begin
            expPc       = `FETCH_RESET_PC;
            expDelay    = 1'b0;
            excActive   = 1'b0;
            jumpPending = 1'b0;
        end else if (active) begin
            if (exception_i) begin
                excActive = 1'b1;
            end
            if (!bubble_i && excActive) begin
                $display("%s: a word was delivered while an exception was pending", testName);
                errorCount_o++;
                testErrors++;
            end else if (!bubble_i) begin
                want = expectWord(expPc, expDelay);
                got  = fetched_i;
                // Fault words carry no meaningful instruction
                if (want.addressError || want.tlbMiss || want.tlbInvalid) begin
                    got.instr = '0;
                end
                if (got !== want) begin
                    reportMismatch(want, got);
                end
            end
            // A word is consumed only when the pipeline is not stalled
            if (!bubble_i && !stall_i) begin
                wordCount_o++;
                testWords++;
                if (absJump_i || jumpPending) begin
                    expPc       = absJump_i ? absJumpAddress_i : jumpTarget;
                    expDelay    = 1'b1;
                    jumpPending = 1'b0;
                end else begin
                    expPc    = expPc + 32'd4;
                    expDelay = 1'b0;
                end
            end else if (absJump_i) begin
                jumpTarget  = absJumpAddress_i;
                jumpPending = 1'b1;
            end
            // A jump ends the exception and the next word is the target
            if (excActive && jumpPending) begin
                expPc       = jumpTarget;
                expDelay    = 1'b1;
                jumpPending = 1'b0;
                excActive   = 1'b0;
            end
        end
    end

endmodule

/* testbench/fetchTb.sv */
`include "fetch_consts.svh"

module fetchTb;
    timeunit 1ns;
    timeprecision 100ps;

    import fetchPkg::*;

    logic                    clk;
    logic                    reset;
    logic                    absJump;
    logic [31:0]             absJumpAddress;
    logic                    stall;
    logic                    exception;
    logic                    loadEn;
    logic [`IMEM_ADDR_W-1:0] loadAddr;
    logic [31:0]             loadData;
    fetchOut_t               fetched;
    logic                    bubble;
    int                      wordCount;
    int                      errorCount;
    int                      assertFails;
    logic                    hung;

    fetchTop u_dut (
        .clk              (clk),
        .reset            (reset),
        .absJump_i        (absJump),
        .absJumpAddress_i (absJumpAddress),
        .stall_i          (stall),
        .exception_i      (exception),
        .loadEn_i         (loadEn),
        .loadAddr_i       (loadAddr),
        .loadData_i       (loadData),
        .fetched_o        (fetched),
        .bubble_o         (bubble)
    );

    fetchChecker chk (
        .clk              (clk),
        .reset            (reset),
        .absJump_i        (absJump),
        .absJumpAddress_i (absJumpAddress),
        .stall_i          (stall),
        .exception_i      (exception),
        .loadEn_i         (loadEn),
        .loadAddr_i       (loadAddr),
        .loadData_i       (loadData),
        .fetched_i        (fetched),
        .bubble_i         (bubble),
        .wordCount_o      (wordCount),
        .errorCount_o     (errorCount)
    );

    always #10 clk = ~clk;

    task automatic applyReset();
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    // Boot code through the load port, one word per cycle
    task automatic loadRam();
        for (int i = 0; i < (1 << `IMEM_ADDR_W); i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = i[`IMEM_ADDR_W-1:0];
            loadData = $urandom;
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    task automatic jumpTo(input logic [31:0] target);
        @(negedge clk);
        absJump        = 1'b1;
        absJumpAddress = target;
        @(negedge clk);
        absJump = 1'b0;
    endtask

    // Each word gets its own 200 cycle limit
    task automatic waitWords(input int n, input logic randomStall, input string what);
        int target;
        int last;
        int idle;
        target = wordCount + n;
        last   = wordCount;
        idle   = 0;
        while (!hung && wordCount < target) begin
            @(negedge clk);
            stall = randomStall && (($urandom % 3) == 0);
            if (wordCount != last) begin
                last = wordCount;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle >= 200) begin
                $display("Timeout: no instruction delivered within 200 cycles during %s", what);
                hung = 1'b1;
            end
        end
        stall = 1'b0;
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        absJump        = 1'b0;
        absJumpAddress = '0;
        stall          = 1'b0;
        exception      = 1'b0;
        loadEn         = 1'b0;
        loadAddr       = '0;
        loadData       = '0;
        hung           = 1'b0;
        void'($urandom(32'ha490));
        applyReset();
        loadRam();

        chk.beginTest("boot stream");
        applyReset();
        waitWords(64, 1'b0, "boot stream");
        chk.endTest();

        chk.beginTest("stall");
        waitWords(48, 1'b1, "stall");
        chk.endTest();

        chk.beginTest("jump");
        jumpTo(32'h80000000 | ($urandom & 32'h1FFFFFFC));
        waitWords(16, 1'b0, "jump");
        chk.endTest();

        chk.beginTest("exception");
        @(negedge clk);
        exception = 1'b1;
        @(negedge clk);
        exception = 1'b0;
        // No word may come out during this window
        repeat (30) @(negedge clk);
        jumpTo(32'h80000000 | ($urandom & 32'h1FFFFFFC));
        waitWords(16, 1'b0, "exception");
        chk.endTest();

        chk.beginTest("faults");
        jumpTo($urandom & 32'h7FFFFFFC);
        waitWords(8, 1'b0, "faults");
        jumpTo(32'hC0000000 | ($urandom & 32'h3FFFFFFC));
        waitWords(8, 1'b0, "faults");
        jumpTo(32'h80000000 | ($urandom & 32'h1FFFFFFC) | 32'h1);
        waitWords(8, 1'b0, "faults");
        jumpTo(32'h80000000 | ($urandom & 32'h1FFFFFFC));
        waitWords(8, 1'b0, "faults");
        chk.endTest();

        assertFails = u_dut.uAssert.failCount;
        $display("Words %0d, mismatches %0d, assertion failures %0d, timeouts %0d",
                 wordCount, errorCount, assertFails, hung);
        if (errorCount == 0 && assertFails == 0 && !hung) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hdl/fetchPkg.sv
hdl/instFetch.sv
hdl/addrTranslate.sv
hdl/instRam.sv
hdl/fetchTop.sv
testbench/fetchTop_assert.sv
testbench/fetchChecker.sv
testbench/fetchTb.sv
